// File: rtl/DataRam.sv
`timescale 1ns/1ps

module DataRam (
    input  logic                                 clk,
    input  logic                                 re_n,
    input  logic [$clog2(LsuPkg::RAM_WORDS)-1:0] raddr,
    input  logic                                 we_n,
    input  logic [$clog2(LsuPkg::RAM_WORDS)-1:0] waddr,
    input  logic [31:0]                          wdata,
    input  logic [3:0]                           wmask,
    output logic [31:0]                          rdata
);
    logic [31:0] mem [LsuPkg::RAM_WORDS];

    initial begin
        for (int i = 0; i < LsuPkg::RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Read returns the old word if the same word is written on that edge.
    always_ff @(posedge clk) begin
        if (!re_n) rdata <= mem[raddr];
        if (!we_n) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

endmodule

// File: rtl/LoadStoreUnit.sv
`timescale 1ns/1ps

module LoadStoreUnit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  branchTaken,
    input  logic [LsuPkg::SQN_W-1:0]              branchSqN,
    input  logic                                  ldValid,
    input  logic [31:0]                           ldAddr,
    input  logic [1:0]                            ldSize,
    input  logic                                  ldSignExtend,
    input  logic [LsuPkg::TAG_W-1:0]              ldTag,
    input  logic [LsuPkg::SQN_W-1:0]              ldSqN,
    input  logic [1:0]                            ldException,
    input  logic [3:0]                            fwdMask,
    input  logic [31:0]                           fwdData,
    input  logic                                  issueValid,
    input  logic [31:0]                           issueAddr,
    input  logic [31:0]                           issueData,
    input  logic [3:0]                            issueWmask,
    input  logic [31:0]                           ramRdata,
    input  logic [31:0]                           mmioRdata,
    input  logic                                  mmioWbusy,
    output logic                                  stStall,
    output logic                                  ramRe_n,
    output logic [$clog2(LsuPkg::RAM_WORDS)-1:0]  ramRaddr,
    output logic                                  ramWe_n,
    output logic [$clog2(LsuPkg::RAM_WORDS)-1:0]  ramWaddr,
    output logic [31:0]                           ramWdata,
    output logic [3:0]                            ramWmask,
    output logic                                  mmioRe_n,
    output logic [3:0]                            mmioRaddr,
    output logic                                  mmioWe_n,
    output logic [3:0]                            mmioWaddr,
    output logic [31:0]                           mmioWdata,
    output logic [3:0]                            mmioWmask,
    output logic [31:0]                           lookupAddr,
    output logic [LsuPkg::SQN_W-1:0]              lookupSqN,
    output logic                                  resValid,
    output logic [31:0]                           resData,
    output logic [LsuPkg::TAG_W-1:0]              resTag,
    output logic [LsuPkg::SQN_W-1:0]              resSqN,
    output logic [2:0]                            resFlags
);
    localparam int RAM_AW = $clog2(LsuPkg::RAM_WORDS);

    logic ldIsMmio, stIsMmio;
    logic ldDrop, s0Drop, s1Drop;
    logic ldKeep, s0Keep, fastPath, doRead;

    logic s0Valid, s0Sext, s0Mmio;
    logic [1:0] s0Off, s0Size, s0Exc;
    logic [LsuPkg::TAG_W-1:0] s0Tag;
    logic [LsuPkg::SQN_W-1:0] s0SqN;
    logic [3:0] s0Mask;
    LsuPkg::MemWord s0Fwd;

    logic s1Valid, s1Sext;
    logic [1:0] s1Off, s1Size, s1Exc;
    logic [LsuPkg::TAG_W-1:0] s1Tag;
    logic [LsuPkg::SQN_W-1:0] s1SqN;
    LsuPkg::MemWord s1Word;

    LsuPkg::MemWord fwdWord, readWord, mergedWord;

    assign ldIsMmio = ldAddr[31:28] == LsuPkg::MMIO_BASE;
    assign stIsMmio = issueAddr[31:28] == LsuPkg::MMIO_BASE;

    // A load is dropped when it is younger than the mispredicted branch.
    assign ldDrop = branchTaken && $signed(ldSqN - branchSqN) > 0;
    assign s0Drop = branchTaken && $signed(s0SqN - branchSqN) > 0;
    assign s1Drop = branchTaken && $signed(s1SqN - branchSqN) > 0;

    assign ldKeep = ldValid && !ldDrop;
    assign s0Keep = s0Valid && !s0Drop;
    assign fastPath = ldKeep && fwdMask == 4'b1111 && !s0Keep;  // Skips stage 0.
    assign doRead = ldKeep && fwdMask != 4'b1111;

    assign lookupAddr = ldAddr;
    assign lookupSqN = ldSqN;
    assign fwdWord.word = fwdData;

    assign ramRaddr = ldAddr[2 +: RAM_AW];
    assign mmioRaddr = ldAddr[3:0];
    assign ramWaddr = issueAddr[2 +: RAM_AW];
    assign ramWdata = issueData;
    assign ramWmask = issueWmask;
    assign mmioWaddr = issueAddr[3:0];
    assign mmioWdata = issueData;
    assign mmioWmask = issueWmask;

    always_comb begin
        ramRe_n = !(doRead && !ldIsMmio);
        mmioRe_n = !(doRead && ldIsMmio);
        stStall = 1'b0;
        ramWe_n = 1'b1;
        mmioWe_n = 1'b1;
        if (issueValid) begin
            if (stIsMmio) begin
                stStall = mmioWbusy;
                mmioWe_n = mmioWbusy;
            end else if (!ramRe_n && ldAddr[31:2] == issueAddr[31:2]) begin
                // Never read and write the same RAM word on one edge.
                stStall = 1'b1;
            end else begin
                ramWe_n = 1'b0;
            end
        end
    end

    // Forwarded lanes win over the lanes read from memory.
    always_comb begin
        readWord.word = s0Mmio ? mmioRdata : ramRdata;
        mergedWord = readWord;
        for (int b = 0; b < 4; b++) begin
            if (s0Mask[b]) mergedWord.lanes[b] = s0Fwd.lanes[b];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
        end else begin
            s0Valid <= ldKeep && !fastPath;
            s1Valid <= s0Keep || fastPath;
        end
    end

    always_ff @(posedge clk) begin
        if (ldValid) begin
            s0Off <= ldAddr[1:0];
            s0Size <= ldSize;
            s0Sext <= ldSignExtend;
            s0Tag <= ldTag;
            s0SqN <= ldSqN;
            s0Exc <= ldException;
            s0Mmio <= ldIsMmio;
            s0Mask <= fwdMask;
            s0Fwd <= fwdWord;
        end
        if (fastPath) begin
            s1Word <= fwdWord;
            s1Off <= ldAddr[1:0];
            s1Size <= ldSize;
            s1Sext <= ldSignExtend;
            s1Tag <= ldTag;
            s1SqN <= ldSqN;
            s1Exc <= ldException;
        end else if (s0Valid) begin
            s1Word <= mergedWord;
            s1Off <= s0Off;
            s1Size <= s0Size;
            s1Sext <= s0Sext;
            s1Tag <= s0Tag;
            s1SqN <= s0SqN;
            s1Exc <= s0Exc;
        end
    end

    always_comb begin
        logic [31:0] shifted;
        shifted = s1Word.word >> {s1Off, 3'b000};
        case (s1Size)
            LsuPkg::SIZE_BYTE: resData = {{24{s1Sext & shifted[7]}}, shifted[7:0]};
            LsuPkg::SIZE_HALF: resData = {{16{s1Sext & shifted[15]}}, shifted[15:0]};
            LsuPkg::SIZE_WORD: resData = shifted;
            default: resData = shifted;
        endcase
    end

    always_comb begin
        case (s1Exc)
            LsuPkg::AGU_MISALIGN: resFlags = LsuPkg::FLAGS_LD_MA;
            LsuPkg::AGU_ACCESS_FAULT: resFlags = LsuPkg::FLAGS_LD_AF;
            LsuPkg::AGU_PAGE_FAULT: resFlags = LsuPkg::FLAGS_LD_PF;
            default: resFlags = LsuPkg::FLAGS_NONE;
        endcase
    end

    assign resValid = s1Valid && !s1Drop;  // A branch in the output cycle still kills it.
    assign resTag = s1Tag;
    assign resSqN = s1SqN;

    assert property (@(posedge clk) disable iff (rst) !(!ramRe_n && !mmioRe_n));

    // A load flushed on arrival must not show up as a result one cycle later.
    assert property (@(posedge clk) disable iff (rst)
        (ldValid && ldDrop) |=> !(resValid && resTag == $past(ldTag)));

endmodule

// File: rtl/LsuPkg.sv
package LsuPkg;

    localparam int TAG_W = 6;
    localparam int SQN_W = 7;      // Compared as a signed difference, so it may wrap.
    localparam int SQ_DEPTH = 8;
    localparam int RAM_WORDS = 256;

    // Addresses whose top nibble matches this value go to the timer device.
    localparam logic [3:0] MMIO_BASE = 4'hF;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // Exception codes delivered by address generation.
    localparam logic [1:0] AGU_NONE = 2'd0;
    localparam logic [1:0] AGU_MISALIGN = 2'd1;
    localparam logic [1:0] AGU_ACCESS_FAULT = 2'd2;
    localparam logic [1:0] AGU_PAGE_FAULT = 2'd3;

    // Result flags reported with each load.
    localparam logic [2:0] FLAGS_NONE = 3'd0;
    localparam logic [2:0] FLAGS_LD_MA = 3'd3;
    localparam logic [2:0] FLAGS_LD_AF = 3'd4;
    localparam logic [2:0] FLAGS_LD_PF = 3'd5;

    // One data word, seen whole or as four byte lanes with lane 0 at the lowest address.
    typedef union packed {
        logic [31:0] word;
        logic [3:0][7:0] lanes;
    } MemWord;

endpackage

// File: rtl/MemorySubsystem.sv
`timescale 1ns/1ps

module MemorySubsystem (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     branchTaken,
    input  logic [LsuPkg::SQN_W-1:0] branchSqN,
    input  logic                     ldValid,
    input  logic [31:0]              ldAddr,
    input  logic [1:0]               ldSize,
    input  logic                     ldSignExtend,
    input  logic [LsuPkg::TAG_W-1:0] ldTag,
    input  logic [LsuPkg::SQN_W-1:0] ldSqN,
    input  logic [1:0]               ldException,
    input  logic                     stValid,
    input  logic [31:0]              stAddr,
    input  logic [31:0]              stData,
    input  logic [3:0]               stWmask,
    input  logic                     commitValid,
    output logic                     resValid,
    output logic [31:0]              resData,
    output logic [LsuPkg::TAG_W-1:0] resTag,
    output logic [LsuPkg::SQN_W-1:0] resSqN,
    output logic [2:0]               resFlags,
    output logic                     sqFull
);
    logic [31:0] lookupAddr, fwdData, issueAddr, issueData;
    logic [LsuPkg::SQN_W-1:0] lookupSqN;
    logic [3:0] fwdMask, issueWmask;
    logic issueValid, stStall;

    logic ramRe_n, ramWe_n;
    logic [$clog2(LsuPkg::RAM_WORDS)-1:0] ramRaddr, ramWaddr;
    logic [31:0] ramRdata, ramWdata;
    logic [3:0] ramWmask;

    logic mmioRe_n, mmioWe_n, mmioWbusy;
    logic [3:0] mmioRaddr, mmioWaddr, mmioWmask;
    logic [31:0] mmioRdata, mmioWdata;

    StoreQueue storeQueue (.*);

    LoadStoreUnit loadStoreUnit (.*);

    DataRam dataRam (
        .clk(clk), .re_n(ramRe_n), .raddr(ramRaddr), .rdata(ramRdata),
        .we_n(ramWe_n), .waddr(ramWaddr), .wdata(ramWdata), .wmask(ramWmask)
    );

    MmioTimer mmioTimer (
        .clk(clk), .rst(rst), .re_n(mmioRe_n), .raddr(mmioRaddr), .rdata(mmioRdata),
        .we_n(mmioWe_n), .waddr(mmioWaddr), .wdata(mmioWdata), .wmask(mmioWmask),
        .wbusy(mmioWbusy)
    );

endmodule

// File: rtl/MmioTimer.sv
`timescale 1ns/1ps

module MmioTimer (
    input  logic        clk,
    input  logic        rst,
    input  logic        re_n,
    input  logic [3:0]  raddr,
    input  logic        we_n,
    input  logic [3:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wmask,
    output logic [31:0] rdata,
    output logic        wbusy
);
    logic [31:0] cycles;
    logic [1:0] busyCnt;
    LsuPkg::MemWord scratch;
    LsuPkg::MemWord wdataWord;

    assign wdataWord.word = wdata;
    assign wbusy = busyCnt != 2'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycles <= '0;
            busyCnt <= '0;
            scratch <= '0;
        end else begin
            cycles <= cycles + 1'b1;
            if (!we_n) begin
                busyCnt <= 2'd3;  // Busy for three cycles after each write.
                if (waddr[3:2] == 2'd1) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wmask[b]) scratch.lanes[b] <= wdataWord.lanes[b];
                    end
                end
            end else if (busyCnt != 2'd0) begin
                busyCnt <= busyCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!re_n) begin
            case (raddr[3:2])
                2'd0: rdata <= cycles;
                2'd1: rdata <= scratch.word;
                2'd2: rdata <= ~scratch.word;
                default: rdata <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) !we_n |-> !wbusy);

endmodule

// File: rtl/StoreQueue.sv
`timescale 1ns/1ps

module StoreQueue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stValid,
    input  logic [31:0]              stAddr,
    input  logic [31:0]              stData,
    input  logic [3:0]               stWmask,
    input  logic                     commitValid,
    input  logic                     branchTaken,
    input  logic [LsuPkg::SQN_W-1:0] branchSqN,
    input  logic [31:0]              lookupAddr,
    input  logic [LsuPkg::SQN_W-1:0] lookupSqN,
    input  logic                     stStall,
    output logic                     sqFull,
    output logic [3:0]               fwdMask,
    output logic [31:0]              fwdData,
    output logic                     issueValid,
    output logic [31:0]              issueAddr,
    output logic [31:0]              issueData,
    output logic [3:0]               issueWmask
);
    localparam int PW = $clog2(LsuPkg::SQ_DEPTH);
    localparam int SW = LsuPkg::SQN_W;

    // Pointers carry one wrap bit above the index.
    logic [PW:0] head, cmt, tail, count, drop, tailNext;
    logic [SW-1:0] tailSqN, sqNNext;
    logic [PW-1:0] wrIdx;
    logic enq;

    logic [31:0] entAddr [LsuPkg::SQ_DEPTH];
    LsuPkg::MemWord entData [LsuPkg::SQ_DEPTH];
    logic [3:0] entMask [LsuPkg::SQ_DEPTH];
    logic [SW-1:0] entSqN [LsuPkg::SQ_DEPTH];

    LsuPkg::MemWord fwdWord;

    assign count = tail - head;
    assign sqFull = count == (PW+1)'(LsuPkg::SQ_DEPTH);
    assign issueValid = head != cmt;  // Only committed entries may drain.
    assign issueAddr = entAddr[head[PW-1:0]];
    assign issueData = entData[head[PW-1:0]].word;
    assign issueWmask = entMask[head[PW-1:0]];

    // A store arriving with a branch lands after the rollback and takes the restored number.
    always_comb begin
        logic [PW:0] cmtNext;
        logic [PW:0] pending;
        logic [SW-1:0] beyond;
        cmtNext = cmt + (PW+1)'(commitValid);
        pending = tail - cmtNext;
        beyond = tailSqN - branchSqN - 1'b1;
        drop = '0;
        if (branchTaken && $signed(beyond) > 0) begin
            if (beyond > SW'(pending))
                drop = pending;
            else
                drop = beyond[PW:0];
        end
        enq = stValid && !sqFull;
        wrIdx = tail[PW-1:0] - drop[PW-1:0];
        tailNext = tail - drop + (PW+1)'(enq);
        sqNNext = tailSqN - SW'(drop) + SW'(enq);
    end

    // Oldest to youngest, so the youngest matching store owns each lane.
    always_comb begin
        logic [PW-1:0] idx;
        fwdMask = '0;
        fwdWord = '0;
        for (int i = 0; i < LsuPkg::SQ_DEPTH; i++) begin
            idx = head[PW-1:0] + PW'(i);
            if ((PW+1)'(i) < count && $signed(entSqN[idx] - lookupSqN) < 0 &&
                    entAddr[idx][31:2] == lookupAddr[31:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (entMask[idx][b]) begin
                        fwdMask[b] = 1'b1;
                        fwdWord.lanes[b] = entData[idx].lanes[b];
                    end
                end
            end
        end
    end

    assign fwdData = fwdWord.word;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            cmt <= '0;
            tail <= '0;
            tailSqN <= '0;
        end else begin
            if (issueValid && !stStall) head <= head + 1'b1;
            if (commitValid) cmt <= cmt + 1'b1;
            tail <= tailNext;
            tailSqN <= sqNNext;
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            entAddr[wrIdx] <= stAddr;
            entData[wrIdx].word <= stData;
            entMask[wrIdx] <= stWmask;
            entSqN[wrIdx] <= tailSqN - SW'(drop);
        end
    end

    assert property (@(posedge clk) disable iff (rst) stValid |-> !sqFull);

    assert property (@(posedge clk) disable iff (rst) commitValid |-> cmt != tail);

endmodule

// File: run.sh
#!/bin/sh
# Builds the LSU testbench with Verilator, runs it and scans the log for a failure.
verilator --binary --timing --assert -f sources.f --top-module LsuTb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/VLsuTb > sim.log 2>&1 \
    || { echo "Simulation aborted, see sim.log"; exit 1; }
grep -q ">>> FAIL" sim.log \
    && { echo "Simulation reported failure, see sim.log"; exit 1; }
echo "Simulation passed"

// File: sources.f
rtl/LsuPkg.sv
rtl/DataRam.sv
rtl/MmioTimer.sv
rtl/StoreQueue.sv
rtl/LoadStoreUnit.sv
rtl/MemorySubsystem.sv
tests/LsuTb.sv

// File: tests/LsuTb.sv
`timescale 1ns/1ps

module LsuTb;
    localparam int N_RANDOM = 400;
    localparam int N_DIRECTED = 120;
    localparam int LIMIT = (N_RANDOM + N_DIRECTED) * 8 + 200;
    localparam logic [31:0] RAM_BASE = 32'h0000_0080;
    localparam logic [31:0] TIMER = 32'hF000_0000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic branchTaken = 1'b0, ldValid = 1'b0, ldSignExtend = 1'b0;
    logic stValid = 1'b0, commitValid = 1'b0;
    logic [LsuPkg::SQN_W-1:0] branchSqN = '0, ldSqN = '0;
    logic [LsuPkg::TAG_W-1:0] ldTag = '0;
    logic [31:0] ldAddr = '0, stAddr = '0, stData = '0;
    logic [1:0] ldSize = '0, ldException = '0;
    logic [3:0] stWmask = '0;
    logic resValid, sqFull;
    logic [31:0] resData;
    logic [LsuPkg::TAG_W-1:0] resTag;
    logic [LsuPkg::SQN_W-1:0] resSqN;
    logic [2:0] resFlags;

    logic [31:0] seed = 32'd1;
    int cycles = 0, dataErrs = 0, flagErrs = 0, tagErrs = 0, sqNErrs = 0, otherErrs = 0;
    int nSt = 0, nCmt = 0, nextTag = 0;
    string testName = "reset";
    logic [31:0] model [17];  // Sixteen RAM words, then the scratch register.
    logic [31:0] undoOld [int];
    int undoIdx [int];
    logic [31:0] expData [int];
    logic [2:0] expFlags [int];
    int sqNOf [int];
    string testOf [int];
    logic [31:0] counterVals [$];

    MemorySubsystem UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};  // The upper bits of an LCG are the better ones.
    endfunction

    function automatic int wordIndex(logic [31:0] addr);
        if (addr[31:28] == LsuPkg::MMIO_BASE)
            return 16;
        return int'((addr - RAM_BASE) >> 2);
    endfunction

    function automatic logic [31:0] randomWord();
        int w;
        w = int'(rnd() % 17);
        return (w == 16) ? TIMER + 32'd4 : RAM_BASE + 32'(4 * w);
    endfunction

    function automatic logic [31:0] loadValue(logic [31:0] addr, logic [1:0] size, logic sext);
        logic [31:0] w;
        w = (addr == TIMER + 32'd8) ? ~model[16] : model[wordIndex(addr)];
        w = w >> (8 * addr[1:0]);
        case (size)
            LsuPkg::SIZE_BYTE: return sext ? {{24{w[7]}}, w[7:0]} : {24'd0, w[7:0]};
            LsuPkg::SIZE_HALF: return sext ? {{16{w[15]}}, w[15:0]} : {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [2:0] flagFor(logic [1:0] exc);
        case (exc)
            LsuPkg::AGU_MISALIGN: return LsuPkg::FLAGS_LD_MA;
            LsuPkg::AGU_ACCESS_FAULT: return LsuPkg::FLAGS_LD_AF;
            LsuPkg::AGU_PAGE_FAULT: return LsuPkg::FLAGS_LD_PF;
            default: return LsuPkg::FLAGS_NONE;
        endcase
    endfunction

    task automatic checkData(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            dataErrs++;
            $display("[ERROR] %s: data expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlags(string name, logic [2:0] expected, logic [2:0] actual);
        if (actual !== expected) begin
            flagErrs++;
            $display("[ERROR] %s: flags expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkSqN(string name, logic [LsuPkg::SQN_W-1:0] expected,
                            logic [LsuPkg::SQN_W-1:0] actual);
        if (actual !== expected) begin
            sqNErrs++;
            $display("[ERROR] %s: sqN expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkTag(string name, logic [LsuPkg::TAG_W-1:0] actual, output bit known);
        known = !$isunknown(actual) && expData.exists(int'(actual));
        if (!known) begin
            tagErrs++;
            $display("[ERROR] %s: expected an outstanding tag, actual tag %0d", name, actual);
        end
    endtask

    task automatic forget(int t);
        expData.delete(t);
        expFlags.delete(t);
        sqNOf.delete(t);
        testOf.delete(t);
    endtask

    // Results are sampled mid cycle, after the falling edge drive has settled.
    always @(negedge clk) begin
        bit known;
        int t;
        #5;
        if (resValid !== 1'b0) begin
            checkTag(testName, resTag, known);
            if (known) begin
                t = int'(resTag);
                if (testOf[t] == "counter")
                    counterVals.push_back(resData);
                else
                    checkData(testOf[t], expData[t], resData);
                checkFlags(testOf[t], expFlags[t], resFlags);
                checkSqN(testOf[t], sqNOf[t][LsuPkg::SQN_W-1:0], resSqN);
                forget(t);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles, %0d loads unanswered", cycles, expData.num());
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic nextCycle();
        @(negedge clk);
        ldValid = 1'b0;
        stValid = 1'b0;
        commitValid = 1'b0;
        branchTaken = 1'b0;
    endtask

    task automatic load(logic [31:0] addr, logic [1:0] size, logic sext, logic [1:0] exc,
                        string name);
        nextCycle();
        ldValid = 1'b1;
        ldAddr = addr;
        ldSize = size;
        ldSignExtend = sext;
        ldException = exc;
        ldSqN = nSt[LsuPkg::SQN_W-1:0];  // Every store enqueued so far is older.
        ldTag = nextTag[LsuPkg::TAG_W-1:0];
        expData[nextTag] = loadValue(addr, size, sext);
        expFlags[nextTag] = flagFor(exc);
        sqNOf[nextTag] = nSt;
        testOf[nextTag] = name;
        nextTag = (nextTag + 1) % (1 << LsuPkg::TAG_W);
    endtask

    task automatic store(logic [31:0] addr, logic [31:0] data, logic [3:0] mask);
        int w;
        w = wordIndex(addr);
        nextCycle();
        while (sqFull)
            nextCycle();
        undoOld[nSt] = model[w];
        undoIdx[nSt] = w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                model[w][8*b +: 8] = data[8*b +: 8];
        end
        stValid = 1'b1;
        stAddr = addr;
        stData = data;
        stWmask = mask;
        nSt++;
    endtask

    task automatic commit();
        nextCycle();
        commitValid = 1'b1;
        nCmt++;
    endtask

    task automatic commitAll();
        while (nCmt < nSt)
            commit();
        nextCycle();
        while (UUT.issueValid)
            nextCycle();
    endtask

    // Drops the k youngest stores, which must all be uncommitted.
    task automatic branch(int k);
        int b;
        int dropped [$];
        b = nSt - 1 - k;
        nextCycle();
        branchTaken = 1'b1;
        branchSqN = b[LsuPkg::SQN_W-1:0];
        while (nSt > b + 1) begin
            nSt--;
            model[undoIdx[nSt]] = undoOld[nSt];
        end
        foreach (sqNOf[t]) begin
            if (sqNOf[t] > b)
                dropped.push_back(t);
        end
        foreach (dropped[i])
            forget(dropped[i]);
    endtask

    task automatic sweep(logic [31:0] addr, string name);
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off += 1 << s) begin
                for (int x = 0; x < 2; x++)
                    load(addr + 32'(off), s[1:0], x[0], LsuPkg::AGU_NONE, name);
            end
        end
    endtask

    task automatic randomLoad(string name);
        logic [31:0] addr;
        logic [1:0] size;
        logic [1:0] exc;
        size = 2'(rnd() % 3);
        addr = randomWord() + ((rnd() % 4) & ~((32'd1 << size) - 1));
        exc = (rnd() % 4 == 0) ? 2'(rnd() % 4) : LsuPkg::AGU_NONE;
        load(addr, size, rnd() % 2 == 1, exc, name);
    endtask

    initial begin
        int r;
        for (int i = 0; i < 17; i++)
            model[i] = '0;
        repeat (10) @(posedge clk);
        nextCycle();
        rst = 1'b0;
        repeat (3) nextCycle();

        testName = "ramLoads";
        store(RAM_BASE, 32'h80F1_7F9C, 4'hF);
        store(RAM_BASE + 32'd4, rnd(), 4'hF);
        commitAll();
        sweep(RAM_BASE, testName);
        sweep(RAM_BASE + 32'd4, testName);

        testName = "forwarding";
        store(RAM_BASE, 32'hA1B2_C3D4, 4'b0101);  // Lanes 1 and 3 still come from the RAM.
        sweep(RAM_BASE, testName);
        store(RAM_BASE + 32'd24, 32'h8899_AABB, 4'hF);
        sweep(RAM_BASE + 32'd24, testName);  // All four lanes forwarded.
        commitAll();

        testName = "branch";
        store(RAM_BASE + 32'd28, 32'h1234_5678, 4'hF);
        store(RAM_BASE + 32'd32, 32'hCAFE_F00D, 4'hF);
        load(RAM_BASE + 32'd28, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, testName);
        branch(2);
        // A flushed entry left in the queue would now look older than the loads below.
        store(RAM_BASE + 32'd36, 32'h5A5A_5A5A, 4'hF);
        load(RAM_BASE + 32'd28, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, testName);
        load(RAM_BASE + 32'd32, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, testName);

        testName = "timer";
        store(TIMER + 32'd4, 32'h1357_9BDF, 4'hF);
        store(TIMER + 32'd4, 32'h2468_ACE0, 4'b0011);
        store(TIMER + 32'd4, 32'hFF00_0000, 4'b1000);
        commitAll();
        load(TIMER + 32'd4, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, testName);
        load(TIMER + 32'd8, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, testName);
        load(TIMER, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, "counter");
        repeat (5) nextCycle();
        load(TIMER, LsuPkg::SIZE_WORD, 1'b0, LsuPkg::AGU_NONE, "counter");

        testName = "exceptions";
        for (int e = 0; e < 4; e++)
            load(RAM_BASE + 32'(4 * e), LsuPkg::SIZE_WORD, 1'b0, 2'(e), testName);

        testName = "random";
        repeat (N_RANDOM) begin
            r = int'(rnd() % 16);
            if (r < 6)
                randomLoad(testName);
            else if (r < 10 && nSt - nCmt < 6)
                store(randomWord(), rnd(), 4'(rnd() % 15 + 1));
            else if (r < 13 && nCmt < nSt)
                commit();
            else if (r == 13)
                branch(int'(rnd() % (nSt - nCmt + 1)));
            else
                nextCycle();
        end

        testName = "drain";
        while (expData.num() != 0)
            nextCycle();
        repeat (4) nextCycle();
        if (counterVals.size() != 2 || counterVals[1] <= counterVals[0]) begin
            otherErrs++;
            $display("Timer counter did not advance between its two reads");
        end
        $display("Errors: data %0d, flags %0d, tags %0d, sqN %0d, other %0d",
                 dataErrs, flagErrs, tagErrs, sqNErrs, otherErrs);
        if (dataErrs + flagErrs + tagErrs + sqNErrs + otherErrs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
